// ==== filelist.f ====
+incdir+logic
logic/crm_buffer_pkg.sv
logic/ecc_decoder.sv
logic/crm_packet_writer.sv
logic/crm_ring_buffer.sv
logic/crm_packet_reader.sv
logic/crm_rx_top.sv
bench/crm_rx_asserts.sv
bench/crm_rx_tb.sv

// ==== Makefile ====
TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= crm_rx_tb
FILELIST ?= filelist.f
BUILD    ?= obj_dir
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o sim
	./$(BUILD)/sim | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bench/crm_rx_tb.sv ====
// Directed testbench for crm_rx_top; run as the simulation top with the bound assertions.
`include "crm_buffer_macros.svh"

module crm_rx_tb;
	import crm_buffer_pkg::*;

	logic                       clk_rst;
	logic                       arst_n;
	logic                       wr_valid;
	logic                       wr_first;
	logic                       wr_last;
	logic [`CRM_DATA_WIDTH-1:0] wr_data;
	logic [`CRM_ECC_WIDTH-1:0]  wr_ecc;
	logic                       rd_get_data;
	logic                       rd_abort;
	logic                       o_rd_got_data;
	logic [`CRM_DATA_WIDTH-1:0] o_rd_data;
	logic                       o_rd_finished;
	logic                       o_ecc_single;
	logic                       o_ecc_double;
	logic                       o_hw_fail;
	logic                       o_wr_drop;

	logic [31:0] exp_words[$];    // Header and two payload slots per packet.
	logic [1:0]  exp_flags[$];    // Double flag on top, single below.
	int          err_cnt;
	int          tests_run;
	int          tests_failed;
	int          drop_cnt;
	int          seed;

	crm_rx_top dut (
		.clk_rst       (clk_rst),
		.i_arst_n      (arst_n),
		.i_wr_valid    (wr_valid),
		.i_wr_first    (wr_first),
		.i_wr_last     (wr_last),
		.i_wr_data     (wr_data),
		.i_wr_ecc      (wr_ecc),
		.i_rd_get_data (rd_get_data),
		.i_rd_abort    (rd_abort),
		.o_rd_got_data (o_rd_got_data),
		.o_rd_data     (o_rd_data),
		.o_rd_finished (o_rd_finished),
		.o_ecc_single  (o_ecc_single),
		.o_ecc_double  (o_ecc_double),
		.o_hw_fail     (o_hw_fail),
		.o_wr_drop     (o_wr_drop)
	);

	initial begin
		clk_rst = 1'b0;
		forever #2 clk_rst = ~clk_rst;
	end

	always @(negedge clk_rst) begin
		if (o_wr_drop) begin
			drop_cnt++;    // Registered pulse, stable here.
		end
		if (arst_n && o_hw_fail !== 1'b0) begin
			$display("Reader raised o_hw_fail on an illegal counter state");
			err_cnt++;
		end
	end

	// Payload words stored after a header, per the symbol count rule.
	function automatic int words_for(input logic [7:0] sc);
		if (sc > 8'd4) return 2;
		if (sc == 8'd4) return 1;
		return 0;
	endfunction

	task automatic idle(input int n);
		repeat (n) @(negedge clk_rst);
	endtask

	// Sends one frame; payload 0 may carry flipped bits.
	task automatic send_frame(input logic [7:0] sc, input logic [31:0] p0, input logic [31:0] p1,
			input int n_words, input logic [31:0] flip_d, input logic [6:0] flip_e,
			input logic [1:0] flags0, input bit committed);
		logic [31:0] words [3];
		int          cnt;
		words[0] = {16'h0, 4'h3, 4'h0, sc};
		words[1] = p0;
		words[2] = p1;
		cnt      = words_for(sc);
		for (int i = 0; i < n_words; i++) begin
			@(negedge clk_rst);
			wr_valid = 1'b1;
			wr_first = i == 0;
			wr_last  = i == n_words - 1;
			wr_data  = words[i] ^ ((i == 1) ? flip_d : 32'h0);
			wr_ecc   = ecc_check_bits(words[i]) ^ ((i == 1) ? flip_e : 7'h0);
		end
		@(negedge clk_rst);
		wr_valid = 1'b0;
		wr_first = 1'b0;
		wr_last  = 1'b0;
		if (committed) begin
			exp_words.push_back(words[0]);
			exp_flags.push_back(2'b00);
			exp_words.push_back(cnt >= 1 ? (flags0[1] ? p0 ^ flip_d : p0) : 32'h0);
			exp_flags.push_back(cnt >= 1 ? flags0 : 2'b00);
			exp_words.push_back(cnt == 2 ? p1 : 32'h0);
			exp_flags.push_back(2'b00);
		end
	endtask

	task automatic check_word();
		logic [31:0] w;
		logic [1:0]  f;
		if (exp_words.size() == 0) begin
			$display("Reader returned a word that no written packet accounts for");
			err_cnt++;
		end else begin
			w = exp_words.pop_front();
			f = exp_flags.pop_front();
			if (o_rd_data !== w) begin
				$display("Mismatch o_rd_data: got %h expected %h", o_rd_data, w);
				err_cnt++;
			end
			if (o_ecc_single !== f[0]) begin
				$display("Mismatch o_ecc_single: got %h expected %h", o_ecc_single, f[0]);
				err_cnt++;
			end
			if (o_ecc_double !== f[1]) begin
				$display("Mismatch o_ecc_double: got %h expected %h", o_ecc_double, f[1]);
				err_cnt++;
			end
		end
	endtask

	// Reads header and two payload words, then expects the finish pulse.
	task automatic read_packet();
		int got;
		int cyc;
		got = 0;
		cyc = 0;
		@(negedge clk_rst);
		rd_get_data = 1'b1;
		while (got < 3 && cyc < 200) begin
			#1;
			if (o_rd_finished) begin
				$display("Finish pulse came before all three words");
				err_cnt++;
			end
			if (o_rd_got_data) begin
				check_word();
				got++;
			end
			cyc++;
			if (got < 3) @(negedge clk_rst);
		end
		if (got < 3) begin
			$display("Timeout waiting for packet words, got %0d of 3", got);
			err_cnt++;
		end else begin
			@(negedge clk_rst);
			#1;
			if (o_rd_finished !== 1'b1) begin
				$display("Finish pulse did not follow the second payload word");
				err_cnt++;
			end
		end
		@(negedge clk_rst);
		rd_get_data = 1'b0;
	endtask

	// Reads only the header, then aborts the packet.
	task automatic read_header_abort();
		int cyc;
		cyc = 0;
		@(negedge clk_rst);
		rd_get_data = 1'b1;
		#1;
		while (!o_rd_got_data && cyc < 200) begin
			@(negedge clk_rst);
			#1;
			cyc++;
		end
		if (!o_rd_got_data) begin
			$display("Timeout waiting for the header word");
			err_cnt++;
		end else begin
			check_word();
			void'(exp_words.pop_front());    // Skipped payload slots.
			void'(exp_flags.pop_front());
			void'(exp_words.pop_front());
			void'(exp_flags.pop_front());
		end
		@(negedge clk_rst);
		rd_get_data = 1'b0;
		rd_abort    = 1'b1;
		idle(4);
		rd_abort = 1'b0;
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_run++;
		if (err_cnt == err_before) begin
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: FAILED", name);
		end
	endtask

	task automatic test_zero_fill();
		int e;
		e = err_cnt;
		send_frame(8'd2, 32'h0, 32'h0, 1, 32'h0, 7'h0, 2'b00, 1'b1);
		read_packet();
		report_test("zero_fill", e);
	endtask

	task automatic test_payload_counts();
		int e;
		e = err_cnt;
		send_frame(8'd4, 32'hA5A5_0001, 32'h0, 2, 32'h0, 7'h0, 2'b00, 1'b1);
		read_packet();
		send_frame(8'd7, 32'h1234_5678, 32'h9ABC_DEF0, 3, 32'h0, 7'h0, 2'b00, 1'b1);
		read_packet();
		report_test("payload_counts", e);
	endtask

	task automatic test_abort();
		int e;
		e = err_cnt;
		send_frame(8'd9, 32'hDEAD_0001, 32'hDEAD_0002, 3, 32'h0, 7'h0, 2'b00, 1'b1);
		send_frame(8'd8, 32'hBEEF_0001, 32'hBEEF_0002, 3, 32'h0, 7'h0, 2'b00, 1'b1);
		read_header_abort();
		read_packet();
		report_test("abort", e);
	endtask

	task automatic test_ecc();
		int e;
		e = err_cnt;
		send_frame(8'd7, 32'h0F0F_1234, 32'h5555_AAAA, 3, 32'h0000_0020, 7'h0, 2'b01, 1'b1);
		read_packet();
		send_frame(8'd7, 32'h0F0F_4321, 32'h3333_CCCC, 3, 32'h0, 7'h04, 2'b01, 1'b1);
		read_packet();
		send_frame(8'd7, 32'h7777_8888, 32'h1111_2222, 3, 32'h0000_0208, 7'h0, 2'b10, 1'b1);
		read_packet();
		report_test("ecc", e);
	endtask

	task automatic test_overflow();
		int e;
		int d;
		e = err_cnt;
		d = drop_cnt;
		send_frame(8'd7, 32'h0000_1111, 32'h0000_2222, 3, 32'h0, 7'h0, 2'b00, 1'b1);
		send_frame(8'd7, 32'h0000_3333, 32'h0000_4444, 3, 32'h0, 7'h0, 2'b00, 1'b1);
		send_frame(8'd7, 32'h0000_5555, 32'h0000_6666, 3, 32'h0, 7'h0, 2'b00, 1'b0);
		idle(2);
		if (drop_cnt != d + 1) begin
			$display("Mismatch o_wr_drop pulses: got %h expected %h", drop_cnt - d, 1);
			err_cnt++;
		end
		read_packet();
		read_packet();
		d = drop_cnt;
		send_frame(8'd7, 32'h0000_7777, 32'h0000_8888, 2, 32'h0, 7'h0, 2'b00, 1'b0);
		idle(2);
		if (drop_cnt != d + 1) begin
			$display("Frame with a misplaced last marker was not dropped");
			err_cnt++;
		end
		send_frame(8'd5, 32'h0000_9999, 32'h0000_AAAA, 3, 32'h0, 7'h0, 2'b00, 1'b1);
		read_packet();
		report_test("overflow", e);
	endtask

	task automatic test_contention();
		int e;
		int d;
		e = err_cnt;
		d = drop_cnt;
		fork
			begin
				int cyc;
				logic [7:0] sc;
				for (int i = 0; i < 6; i++) begin
					cyc = 0;
					while (exp_words.size() > 3 && cyc < 400) begin
						@(negedge clk_rst);
						cyc++;
					end
					if (exp_words.size() > 3) begin
						$display("Timeout waiting for room to send packet %0d", i);
						err_cnt++;
					end
					case ($unsigned($random(seed)) % 3)
						0:       sc = 8'd3;
						1:       sc = 8'd4;
						default: sc = 8'd6;
					endcase
					send_frame(sc, $random(seed), $random(seed), words_for(sc) + 1,
						32'h0, 7'h0, 2'b00, 1'b1);
				end
			end
			begin
				for (int i = 0; i < 6; i++) begin
					read_packet();
				end
			end
		join
		if (drop_cnt != d) begin
			$display("Writer dropped a packet while the reader was reading");
			err_cnt++;
		end
		report_test("contention", e);
	endtask

	initial begin
		arst_n       = 1'b0;
		wr_valid     = 1'b0;
		wr_first     = 1'b0;
		wr_last      = 1'b0;
		wr_data      = '0;
		wr_ecc       = '0;
		rd_get_data  = 1'b0;
		rd_abort     = 1'b0;
		err_cnt      = 0;
		tests_run    = 0;
		tests_failed = 0;
		drop_cnt     = 0;
		seed         = 32'h6662;
		repeat (8) @(negedge clk_rst);
		arst_n = 1'b1;
		idle(2);
		test_zero_fill();
		test_payload_counts();
		test_abort();
		test_ecc();
		test_overflow();
		test_contention();
		if (exp_words.size() != 0) begin
			$display("Model still holds %0d words that were never read", exp_words.size());
			err_cnt++;
		end
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0 && tests_failed == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== bench/crm_rx_asserts.sv ====
// Protocol checks on the CRM receive top level; bound into crm_rx_top from this file.
module crm_rx_asserts (
	input logic clk_rst,
	input logic i_arst_n,
	input logic o_rd_got_data,
	input logic o_rd_finished,
	input logic o_ecc_single,
	input logic o_ecc_double,
	input logic o_hw_fail
);

	// A finish cycle never delivers a word.
	got_vs_finished: assert property (@(posedge clk_rst) disable iff (!i_arst_n)
		!(o_rd_got_data && o_rd_finished))
		else $error("got_data and finished high in the same cycle");

	// Finish follows straight after the last payload word.
	finish_after_word: assert property (@(posedge clk_rst) disable iff (!i_arst_n)
		o_rd_finished |-> $past(o_rd_got_data))
		else $error("finished without a word in the previous cycle");

	ecc_flags_exclusive: assert property (@(posedge clk_rst) disable iff (!i_arst_n)
		!(o_ecc_single && o_ecc_double))
		else $error("single and double ECC flags high together");

	no_hw_fail: assert property (@(posedge clk_rst) disable iff (!i_arst_n)
		!o_hw_fail)
		else $error("reader raised hw_fail");

endmodule

bind crm_rx_top crm_rx_asserts u_asserts (.*);

// ==== logic/crm_rx_top.sv ====
// CRM receive path top level: packet writer, ECC ring buffer and packet reader wired together.
`include "crm_buffer_macros.svh"

module crm_rx_top (
	input  logic                       clk_rst,
	input  logic                       i_arst_n,
	input  logic                       i_wr_valid,
	input  logic                       i_wr_first,
	input  logic                       i_wr_last,
	input  logic [`CRM_DATA_WIDTH-1:0] i_wr_data,
	input  logic [`CRM_ECC_WIDTH-1:0]  i_wr_ecc,
	input  logic                       i_rd_get_data,
	input  logic                       i_rd_abort,
	output logic                       o_rd_got_data,
	output logic [`CRM_DATA_WIDTH-1:0] o_rd_data,
	output logic                       o_rd_finished,
	output logic                       o_ecc_single,
	output logic                       o_ecc_double,
	output logic                       o_hw_fail,
	output logic                       o_wr_drop
);
	import crm_buffer_pkg::*;

	logic                     wr_req;
	logic [`CRM_BUF_AW-1:0]   wr_addr_offset;
	logic [`CRM_CW_WIDTH-1:0] wr_codeword;
	logic [`CRM_BUF_AW-1:0]   wr_free;
	logic                     wr_commit;
	logic [`CRM_BUF_AW-1:0]   wr_commit_len;
	buffer_action_e           rd_action;
	logic [`CRM_BUF_AW-1:0]   rd_step;
	logic                     rd_ready;
	logic [`CRM_CW_WIDTH-1:0] rd_codeword;

	crm_packet_writer u_writer (
		.clk_rst      (clk_rst),
		.i_arst_n     (i_arst_n),
		.i_wr_valid   (i_wr_valid),
		.i_wr_first   (i_wr_first),
		.i_wr_last    (i_wr_last),
		.i_wr_data    (i_wr_data),
		.i_wr_ecc     (i_wr_ecc),
		.i_free       (wr_free),
		.o_req        (wr_req),
		.o_offset     (wr_addr_offset),
		.o_codeword   (wr_codeword),
		.o_commit     (wr_commit),
		.o_commit_len (wr_commit_len),
		.o_drop       (o_wr_drop)
	);

	crm_ring_buffer u_buffer (
		.clk_rst         (clk_rst),
		.i_arst_n        (i_arst_n),
		.i_wr_req        (wr_req),
		.i_wr_offset     (wr_addr_offset),
		.i_wr_codeword   (wr_codeword),
		.i_wr_commit     (wr_commit),
		.i_wr_commit_len (wr_commit_len),
		.i_rd_action     (rd_action),
		.i_rd_step       (rd_step),
		.o_wr_free       (wr_free),
		.o_rd_ready      (rd_ready),
		.o_rd_codeword   (rd_codeword)
	);

	crm_packet_reader u_reader (
		.clk_rst      (clk_rst),
		.i_arst_n     (i_arst_n),
		.i_get_data   (i_rd_get_data),
		.i_abort      (i_rd_abort),
		.i_ready      (rd_ready),
		.i_codeword   (rd_codeword),
		.o_action     (rd_action),
		.o_step       (rd_step),
		.o_got_data   (o_rd_got_data),
		.o_data       (o_rd_data),
		.o_finished   (o_rd_finished),
		.o_ecc_single (o_ecc_single),
		.o_ecc_double (o_ecc_double),
		.o_hw_fail    (o_hw_fail)
	);

endmodule

// ==== logic/crm_packet_reader.sv ====
// Reads one CRM packet from the ring per request: header, then two payload words, zero-filled.
`include "crm_buffer_macros.svh"

module crm_packet_reader (
	input  logic                           clk_rst,
	input  logic                           i_arst_n,
	input  logic                           i_get_data,
	input  logic                           i_abort,
	input  logic                           i_ready,
	input  logic [`CRM_CW_WIDTH-1:0]       i_codeword,
	output crm_buffer_pkg::buffer_action_e o_action,
	output logic [`CRM_BUF_AW-1:0]         o_step,
	output logic                           o_got_data,
	output logic [`CRM_DATA_WIDTH-1:0]     o_data,
	output logic                           o_finished,
	output logic                           o_ecc_single,
	output logic                           o_ecc_double,
	output logic                           o_hw_fail
);
	import crm_buffer_pkg::*;

	typedef enum logic [1:0] {IDLE, READ_HEADER, READ_DATA, FINISH_PACKET} reader_state_e;

	reader_state_e              state;
	reader_state_e              state_next;
	logic [`CRM_BUF_AW-1:0]     word_cnt;
	logic [`CRM_BUF_AW-1:0]     word_cnt_next;
	logic [`CRM_BUF_AW-1:0]     pkt_words;
	logic [`CRM_BUF_AW-1:0]     pkt_words_next;
	logic [`CRM_DATA_WIDTH-1:0] data_corrected;
	crm_word_u                  rd_word;
	logic                       ecc_cor;
	logic                       ecc_err;
	packet_state_e              packet_state;

	ecc_decoder u_ecc_decoder (
		.i_data    (i_codeword[`CRM_DATA_WIDTH-1:0]),
		.i_ecc     (i_codeword[`CRM_CW_WIDTH-1:`CRM_DATA_WIDTH]),
		.o_data    (data_corrected),
		.o_ecc_cor (ecc_cor),
		.o_ecc_err (ecc_err)
	);

	assign rd_word      = crm_word_u'(data_corrected);
	assign o_ecc_single = ecc_cor && o_action == BUFFER_READ;
	assign o_ecc_double = ecc_err && o_action == BUFFER_READ;

	always_ff @(posedge clk_rst or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state     <= IDLE;
			word_cnt  <= '0;
			pkt_words <= '0;
		end else begin
			state     <= state_next;
			word_cnt  <= word_cnt_next;
			pkt_words <= pkt_words_next;
		end
	end

	// Two payload slots per packet, stored or zero.
	always_comb begin
		if (word_cnt >= (`CRM_BUF_AW)'(2)) begin
			packet_state = PACKET_FINISHED;
		end else if (word_cnt < pkt_words) begin
			packet_state = PACKET_ONGOING;
		end else begin
			packet_state = PACKET_FILL_ZERO;
		end
	end

	always_comb begin
		state_next     = state;
		word_cnt_next  = word_cnt;
		pkt_words_next = pkt_words;
		o_action       = IDLE_READ;
		o_step         = '0;
		o_got_data     = 1'b0;
		o_finished     = 1'b0;
		o_hw_fail      = 1'b0;
		o_data         = rd_word.payload;
		case (state)
			IDLE: begin
				if (i_get_data) begin
					state_next    = READ_HEADER;
					word_cnt_next = '0;
				end
			end
			READ_HEADER: begin
				o_action = BUFFER_READ;
				if (i_ready) begin
					o_got_data     = 1'b1;    // Header goes out too.
					pkt_words_next = payload_words(rd_word.header.symbol_count);
					state_next     = i_abort ? FINISH_PACKET : READ_DATA;
				end else if (i_abort) begin
					state_next = IDLE;    // Nothing popped yet.
				end
			end
			READ_DATA: begin
				case (packet_state)
					PACKET_ONGOING: begin
						if (i_get_data) begin
							o_action = BUFFER_READ;
							if (i_ready) begin
								o_got_data    = 1'b1;
								word_cnt_next = word_cnt + (`CRM_BUF_AW)'(1);
							end
						end
						if (i_abort) begin
							state_next = FINISH_PACKET;
						end
					end
					PACKET_FILL_ZERO: begin
						if (i_get_data) begin
							o_data        = '0;
							o_got_data    = 1'b1;
							word_cnt_next = word_cnt + (`CRM_BUF_AW)'(1);
						end
						if (i_abort) begin
							state_next = IDLE;    // Stored words all consumed.
						end
					end
					PACKET_FINISHED: begin
						o_finished = 1'b1;
						o_hw_fail  = word_cnt != (`CRM_BUF_AW)'(2);    // Counter overshoot.
						state_next = IDLE;
					end
					default: begin
						o_finished = 1'b1;
						o_hw_fail  = 1'b1;
						state_next = IDLE;
					end
				endcase
			end
			FINISH_PACKET: begin
				// Skip the stored words not read yet.
				o_action = BUFFER_MOVE_POINTER;
				o_step   = pkt_words - word_cnt;
				if (i_ready) begin
					state_next = IDLE;
				end
			end
			default: state_next = IDLE;
		endcase
	end

endmodule

// ==== logic/crm_ring_buffer.sv ====
// Single-port codeword ring shared by the packet writer and reader, writer first.
`include "crm_buffer_macros.svh"

module crm_ring_buffer (
	input  logic                           clk_rst,
	input  logic                           i_arst_n,
	input  logic                           i_wr_req,
	input  logic [`CRM_BUF_AW-1:0]         i_wr_offset,
	input  logic [`CRM_CW_WIDTH-1:0]       i_wr_codeword,
	input  logic                           i_wr_commit,
	input  logic [`CRM_BUF_AW-1:0]         i_wr_commit_len,
	input  crm_buffer_pkg::buffer_action_e i_rd_action,
	input  logic [`CRM_BUF_AW-1:0]         i_rd_step,
	output logic [`CRM_BUF_AW-1:0]         o_wr_free,
	output logic                           o_rd_ready,
	output logic [`CRM_CW_WIDTH-1:0]       o_rd_codeword
);
	import crm_buffer_pkg::*;

	logic [`CRM_CW_WIDTH-1:0] mem [`CRM_BUF_DEPTH];
	logic [`CRM_BUF_AW-1:0]   rd_ptr;
	logic [`CRM_BUF_AW-1:0]   wr_ptr;
	logic [`CRM_BUF_AW:0]     fill;
	logic [`CRM_BUF_AW:0]     free_cnt;
	logic [`CRM_BUF_AW:0]     fill_add;
	logic [`CRM_BUF_AW:0]     fill_sub;
	logic                     rd_pop;
	logic                     rd_move;

	// The writer owns the port whenever it writes.
	always_comb begin
		case (i_rd_action)
			BUFFER_READ:         o_rd_ready = !i_wr_req && fill != '0;
			BUFFER_MOVE_POINTER: o_rd_ready = !i_wr_req;
			default:             o_rd_ready = 1'b0;
		endcase
	end

	assign rd_pop  = o_rd_ready && i_rd_action == BUFFER_READ;
	assign rd_move = o_rd_ready && i_rd_action == BUFFER_MOVE_POINTER;

	assign o_rd_codeword = mem[rd_ptr];

	assign free_cnt  = (`CRM_BUF_AW + 1)'(`CRM_BUF_DEPTH) - fill;
	assign o_wr_free = free_cnt[`CRM_BUF_AW] ? '1 : free_cnt[`CRM_BUF_AW-1:0];    // Saturated.

	assign fill_add = i_wr_commit ? {1'b0, i_wr_commit_len} : '0;

	always_comb begin
		fill_sub = '0;
		if (rd_pop) begin
			fill_sub = (`CRM_BUF_AW + 1)'(1);
		end else if (rd_move) begin
			fill_sub = {1'b0, i_rd_step};
		end
	end

	always_ff @(posedge clk_rst) begin
		if (i_wr_req) begin
			mem[wr_ptr + i_wr_offset] <= i_wr_codeword;    // Beyond the committed data.
		end
	end

	always_ff @(posedge clk_rst or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			fill   <= '0;
		end else begin
			if (i_wr_commit) begin
				wr_ptr <= wr_ptr + i_wr_commit_len;    // Packet becomes visible.
			end
			if (rd_pop) begin
				rd_ptr <= rd_ptr + (`CRM_BUF_AW)'(1);
			end else if (rd_move) begin
				rd_ptr <= rd_ptr + i_rd_step;
			end
			fill <= fill + fill_add - fill_sub;
		end
	end

endmodule

// ==== logic/crm_packet_writer.sv ====
// Frames incoming CRM response words and commits each complete packet to the ring buffer at once.
`include "crm_buffer_macros.svh"

module crm_packet_writer (
	input  logic                       clk_rst,
	input  logic                       i_arst_n,
	input  logic                       i_wr_valid,
	input  logic                       i_wr_first,
	input  logic                       i_wr_last,
	input  logic [`CRM_DATA_WIDTH-1:0] i_wr_data,
	input  logic [`CRM_ECC_WIDTH-1:0]  i_wr_ecc,
	input  logic [`CRM_BUF_AW-1:0]     i_free,
	output logic                       o_req,
	output logic [`CRM_BUF_AW-1:0]     o_offset,
	output logic [`CRM_CW_WIDTH-1:0]   o_codeword,
	output logic                       o_commit,
	output logic [`CRM_BUF_AW-1:0]     o_commit_len,
	output logic                       o_drop
);
	import crm_buffer_pkg::*;

	crm_word_u              head;
	logic                   in_frame;
	logic [`CRM_BUF_AW-1:0] word_cnt;
	logic [`CRM_BUF_AW-1:0] frame_len;
	logic [`CRM_BUF_AW-1:0] new_len;
	logic [`CRM_BUF_AW-1:0] offset_now;
	logic [`CRM_BUF_AW-1:0] eff_free;
	logic                   wr_accept;
	logic                   commit_now;
	logic                   drop_now;

	assign head     = crm_word_u'(i_wr_data);    // Header view, read before correction.
	assign new_len  = payload_words(head.header.symbol_count) + (`CRM_BUF_AW)'(1);
	// A commit in flight has not reached the fill count yet.
	assign eff_free = o_commit ? i_free - o_commit_len : i_free;

	always_comb begin
		wr_accept  = 1'b0;
		commit_now = 1'b0;
		drop_now   = 1'b0;
		offset_now = word_cnt;
		if (i_wr_valid && i_wr_first) begin
			offset_now = '0;
			drop_now   = in_frame;    // Interrupted frame.
			if (new_len > eff_free) begin
				drop_now = 1'b1;
			end else begin
				wr_accept = 1'b1;
				if (i_wr_last) begin
					commit_now = new_len == (`CRM_BUF_AW)'(1);
					drop_now   = drop_now || new_len != (`CRM_BUF_AW)'(1);
				end
			end
		end else if (i_wr_valid && in_frame) begin
			if (word_cnt >= frame_len) begin
				drop_now = 1'b1;    // More words than the header allows.
			end else begin
				wr_accept = 1'b1;
				if (i_wr_last) begin
					commit_now = word_cnt + (`CRM_BUF_AW)'(1) == frame_len;
					drop_now   = word_cnt + (`CRM_BUF_AW)'(1) != frame_len;
				end
			end
		end
	end

	always_ff @(posedge clk_rst or negedge i_arst_n) begin
		if (!i_arst_n) begin
			in_frame  <= 1'b0;
			word_cnt  <= '0;
			frame_len <= '0;
			o_req     <= 1'b0;
			o_commit  <= 1'b0;
			o_drop    <= 1'b0;
		end else begin
			o_req    <= wr_accept;
			o_commit <= commit_now;
			o_drop   <= drop_now;
			if (i_wr_valid && (i_wr_first || in_frame)) begin
				in_frame <= wr_accept && !i_wr_last;
			end
			if (wr_accept) begin
				word_cnt <= offset_now + (`CRM_BUF_AW)'(1);
			end
			if (i_wr_valid && i_wr_first) begin
				frame_len <= new_len;
			end
		end
	end

	always_ff @(posedge clk_rst) begin
		o_offset     <= offset_now;
		o_codeword   <= {i_wr_ecc, i_wr_data};
		o_commit_len <= offset_now + (`CRM_BUF_AW)'(1);    // Words up to and with this one.
	end

endmodule

// ==== logic/ecc_decoder.sv ====
// SECDED decoder for one buffer codeword; corrects single-bit errors and flags double-bit ones.
`include "crm_buffer_macros.svh"

module ecc_decoder (
	input  logic [`CRM_DATA_WIDTH-1:0] i_data,
	input  logic [`CRM_ECC_WIDTH-1:0]  i_ecc,
	output logic [`CRM_DATA_WIDTH-1:0] o_data,
	output logic                       o_ecc_cor,
	output logic                       o_ecc_err
);
	import crm_buffer_pkg::*;

	logic [`CRM_ECC_WIDTH-1:0] check_diff;
	logic [`CRM_ECC_WIDTH-2:0] syndrome;
	logic                      parity_odd;
	logic                      syndrome_valid;

	assign check_diff     = ecc_check_bits(i_data) ^ i_ecc;
	assign syndrome       = check_diff[`CRM_ECC_WIDTH-2:0];
	assign parity_odd     = ^check_diff;    // Odd count of flipped bits.
	assign syndrome_valid = syndrome < (`CRM_ECC_WIDTH - 1)'(`CRM_DATA_WIDTH + `CRM_ECC_WIDTH);

	assign o_ecc_cor = parity_odd && syndrome_valid;
	assign o_ecc_err = (!parity_odd && syndrome != '0) || (parity_odd && !syndrome_valid);

	// A syndrome on a check-bit position leaves the data alone.
	always_comb begin : correct_blk
		int unsigned bit_idx;
		o_data  = i_data;
		bit_idx = 0;
		for (int pos = 1; pos < `CRM_DATA_WIDTH + `CRM_ECC_WIDTH; pos++) begin
			if ((pos & (pos - 1)) != 0) begin
				if (parity_odd && syndrome == (`CRM_ECC_WIDTH - 1)'(pos)) begin
					o_data[bit_idx] = ~i_data[bit_idx];    // Flip the addressed bit.
				end
				bit_idx++;
			end
		end
	end

endmodule

// ==== logic/crm_buffer_pkg.sv ====
// Types and helper functions for the CRM receive buffer, imported by the RTL and the testbench.
`include "crm_buffer_macros.svh"

package crm_buffer_pkg;

	// A buffer word is either a response header or raw payload.
	typedef union packed {
		struct packed {
			logic [15:0] reserved;
			logic [3:0]  channel_id;
			logic [3:0]  status;
			logic [7:0]  symbol_count;
		} header;
		logic [`CRM_DATA_WIDTH-1:0] payload;
	} crm_word_u;

	typedef enum logic [1:0] {
		IDLE_READ,
		BUFFER_READ,
		BUFFER_MOVE_POINTER
	} buffer_action_e;

	typedef enum logic [1:0] {
		PACKET_ONGOING,
		PACKET_FILL_ZERO,
		PACKET_FINISHED
	} packet_state_e;

	// Hamming bits sit at the power-of-two positions of a 38-bit codeword.
	function automatic logic [`CRM_ECC_WIDTH-1:0] ecc_check_bits(
		input logic [`CRM_DATA_WIDTH-1:0] data
	);
		logic [`CRM_ECC_WIDTH-2:0] hamming;
		int unsigned               bit_idx;
		hamming = '0;
		bit_idx = 0;
		for (int pos = 1; pos < `CRM_DATA_WIDTH + `CRM_ECC_WIDTH; pos++) begin
			if ((pos & (pos - 1)) != 0) begin
				if (data[bit_idx]) begin
					hamming = hamming ^ (`CRM_ECC_WIDTH - 1)'(pos);
				end
				bit_idx++;
			end
		end
		return {^{hamming, data}, hamming};    // Overall parity on top.
	endfunction

	// Stored payload words that follow a header with this symbol count.
	function automatic logic [`CRM_BUF_AW-1:0] payload_words(input logic [7:0] symbol_count);
		if (symbol_count > 8'd4) begin
			return (`CRM_BUF_AW)'(2);
		end
		if (symbol_count == 8'd4) begin
			return (`CRM_BUF_AW)'(1);
		end
		return '0;
	endfunction

endpackage

// ==== logic/crm_buffer_macros.svh ====
// Widths and depth shared by the CRM receive buffer; include in any file that sizes a port.
`ifndef CRM_BUFFER_MACROS_SVH
`define CRM_BUFFER_MACROS_SVH

// One stored codeword is a payload word with its SECDED check bits.
`define CRM_DATA_WIDTH 32
`define CRM_ECC_WIDTH  7
`define CRM_CW_WIDTH   (`CRM_DATA_WIDTH + `CRM_ECC_WIDTH)

// Ring of codewords and its pointer width.
`define CRM_BUF_DEPTH  8
`define CRM_BUF_AW     3

`endif
